/* async_fifo_macros.svh */
/*
  async fifo constants
  sizes shared by the packages and the rtl of the dual clock fifo
*/
`ifndef ASYNC_FIFO_MACROS_SVH
`define ASYNC_FIFO_MACROS_SVH

// number of storage entries, must stay a power of two
`define FIFO_DEPTH 8

// memory index width, log2 of the depth
`define FIFO_ADDR_W 3

// width of one stored word
`define FIFO_DATA_W 8

// flops in each gray pointer synchronizer
`define FIFO_SYNC_STAGES 2

`endif

/* fifo_data_pkg.sv */
/*
  fifo data package
  type of the word carried from the write domain to the read domain
*/
`default_nettype none

`include "async_fifo_macros.svh"

package fifo_data_pkg;

  // one fifo word
  // the same type is used on data_in, in the memory and on data_out
  typedef logic [`FIFO_DATA_W-1:0] data_t;

endpackage : fifo_data_pkg

`default_nettype wire

/* fifo_ptr_pkg.sv */
/*
  fifo pointer package
  address, pointer and binary/gray pointer pair types
*/
`default_nettype none

`include "async_fifo_macros.svh"

package fifo_ptr_pkg;

  // index into the storage array
  typedef logic [`FIFO_ADDR_W-1:0] addr_t;

  // pointer with one extra wrap bit on top
  // the wrap bit tells full apart from empty when the addresses match
  typedef logic [`FIFO_ADDR_W:0] ptr_t;

  // binary form drives the memory address
  // gray form is what crosses into the other clock domain
  typedef struct packed {
    ptr_t bin;
    ptr_t gray;
  } ptr_pair_t;

endpackage : fifo_ptr_pkg

`default_nettype wire

/* gray_sync.sv */
/*
  gray pointer synchronizer
  chain of flops that moves a gray coded pointer into the destination clock domain
*/
`timescale 1ns/1ns
`default_nettype none

`include "async_fifo_macros.svh"

module gray_sync import fifo_ptr_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  ptr_t d,
  output ptr_t q
);

  // flop chain, index 0 samples the foreign domain
  // only one bit of d changes per source edge, so a late sample is off by one step at most
  ptr_t sync_q [`FIFO_SYNC_STAGES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // all stages clear so the pointer looks like reset in both domains
      for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      // first stage may go metastable
      sync_q[0] <= d;
      // remaining stages give it time to settle
      for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // last stage is the settled pointer
  // it follows d after FIFO_SYNC_STAGES destination edges
  assign q = sync_q[`FIFO_SYNC_STAGES-1];

endmodule : gray_sync

`default_nettype wire

/* wptr_full.sv */
/*
  write pointer and full flag
  counts accepted writes, makes the memory write strobe and
  registers a full flag against the synchronized read pointer
*/
`timescale 1ns/1ns
`default_nettype none

`include "async_fifo_macros.svh"

module wptr_full import fifo_ptr_pkg::*; (
  input  logic      wclk,
  input  logic      wrst_n,
  input  logic      w_en,
  input  ptr_t      rptr_gray_sync,
  output addr_t     waddr,
  output ptr_pair_t wptr,
  output logic      wr_fire,
  output logic      full
);

  // next state of the pointer pair
  ptr_t wbin_next;
  ptr_t wgray_next;

  // read pointer as it looks when the writer is one lap ahead
  ptr_t rptr_full_pat;

  // full condition seen from the next pointer
  logic full_next;

  // a write is taken only when the fifo has room
  // writes while full are dropped here and never reach the memory
  assign wr_fire = w_en & ~full;

  // binary pointer steps by one on an accepted write
  assign wbin_next = wptr.bin + ptr_t'(wr_fire);

  // binary to gray, adjacent values differ in one bit
  assign wgray_next = (wbin_next >> 1) ^ wbin_next;

  // in gray code a full lap flips the two top bits
  // the lower bits stay equal to the read pointer
  assign rptr_full_pat = {~rptr_gray_sync[`FIFO_ADDR_W:`FIFO_ADDR_W-1],
                          rptr_gray_sync[`FIFO_ADDR_W-2:0]};

  assign full_next = (wgray_next == rptr_full_pat);

  // memory address is the current pointer without its wrap bit
  // the word lands on the same edge that moves the pointer
  assign waddr = wptr.bin[`FIFO_ADDR_W-1:0];

  always_ff @(posedge wclk or negedge wrst_n) begin
    if (!wrst_n) begin
      wptr <= '0;
      full <= 1'b0;
    end else begin
      wptr.bin  <= wbin_next;
      wptr.gray <= wgray_next;
      // rises on the edge that takes the last free entry
      // falls only once freed space has crossed the synchronizer
      full <= full_next;
    end
  end

endmodule : wptr_full

`default_nettype wire

/* rptr_empty.sv */
/*
  read pointer and empty flag
  counts pops and registers an empty flag against the
  synchronized write pointer
*/
`timescale 1ns/1ns
`default_nettype none

`include "async_fifo_macros.svh"

module rptr_empty import fifo_ptr_pkg::*; (
  input  logic      rclk,
  input  logic      rrst_n,
  input  logic      r_en,
  input  ptr_t      wptr_gray_sync,
  output addr_t     raddr,
  output ptr_pair_t rptr,
  output logic      empty
);

  // a pop happens only when there is data
  logic rd_fire;

  // next state of the pointer pair
  ptr_t rbin_next;
  ptr_t rgray_next;

  // empty condition seen from the next pointer
  logic empty_next;

  // reads while empty leave the pointer where it is
  assign rd_fire = r_en & ~empty;

  assign rbin_next = rptr.bin + ptr_t'(rd_fire);

  // binary to gray for the crossing into wclk
  assign rgray_next = (rbin_next >> 1) ^ rbin_next;

  // empty when both pointers match, wrap bit included
  assign empty_next = (rgray_next == wptr_gray_sync);

  // head of the fifo, read combinationally from the memory
  assign raddr = rptr.bin[`FIFO_ADDR_W-1:0];

  always_ff @(posedge rclk or negedge rrst_n) begin
    if (!rrst_n) begin
      rptr  <= '0;
      // nothing stored after reset
      empty <= 1'b1;
    end else begin
      rptr.bin  <= rbin_next;
      rptr.gray <= rgray_next;
      // rises on the edge of the last pop
      // falls a few rclk after the first write has crossed over
      empty <= empty_next;
    end
  end

endmodule : rptr_empty

`default_nettype wire

/* fifo_ram.sv */
/*
  fifo storage
  dual port array, written on wclk and read combinationally at the read address
*/
`timescale 1ns/1ns
`default_nettype none

`include "async_fifo_macros.svh"

module fifo_ram import fifo_data_pkg::*, fifo_ptr_pkg::*; (
  input  logic  wclk,
  input  logic  wr_fire,
  input  addr_t waddr,
  input  data_t wdata,
  input  addr_t raddr,
  output data_t rdata
);

  // one entry per fifo slot
  data_t mem [`FIFO_DEPTH];

  // write port in the wclk domain
  // the strobe already includes the full check
  always_ff @(posedge wclk) begin
    if (wr_fire) begin
      mem[waddr] <= wdata;
    end
  end

  // read port has no clock
  // the head word shows as soon as raddr points at it
  // the slot under raddr is stable while empty is low
  assign rdata = mem[raddr];

endmodule : fifo_ram

`default_nettype wire

/* async_fifo.sv */
/*
  async fifo top
  dual clock fifo from the wclk domain to the rclk domain,
  first word fall through on the read side
*/
`timescale 1ns/1ns
`default_nettype none

module async_fifo import fifo_data_pkg::*, fifo_ptr_pkg::*; (
  // write domain
  input  logic  wclk,
  input  logic  wrst_n,
  input  logic  w_en,
  input  data_t data_in,
  output logic  full,
  // read domain
  input  logic  rclk,
  input  logic  rrst_n,
  input  logic  r_en,
  output data_t data_out,
  output logic  empty
);

  // pointer pairs owned by each side
  ptr_pair_t wptr;
  ptr_pair_t rptr;

  // gray pointers after crossing
  // wptr_gray_sync lives in rclk, rptr_gray_sync lives in wclk
  ptr_t wptr_gray_sync;
  ptr_t rptr_gray_sync;

  // memory addresses from the binary pointers
  addr_t waddr;
  addr_t raddr;

  // accepted write, one wclk cycle per word
  logic wr_fire;

  // write side pointer, strobe and full flag
  wptr_full u_wptr_full (
    .wclk           (wclk),
    .wrst_n         (wrst_n),
    .w_en           (w_en),
    .rptr_gray_sync (rptr_gray_sync),
    .waddr          (waddr),
    .wptr           (wptr),
    .wr_fire        (wr_fire),
    .full           (full)
  );

  // read side pointer and empty flag
  rptr_empty u_rptr_empty (
    .rclk           (rclk),
    .rrst_n         (rrst_n),
    .r_en           (r_en),
    .wptr_gray_sync (wptr_gray_sync),
    .raddr          (raddr),
    .rptr           (rptr),
    .empty          (empty)
  );

  // write pointer into the read domain
  gray_sync sync_w2r (
    .clk   (rclk),
    .rst_n (rrst_n),
    .d     (wptr.gray),
    .q     (wptr_gray_sync)
  );

  // read pointer into the write domain
  gray_sync sync_r2w (
    .clk   (wclk),
    .rst_n (wrst_n),
    .d     (rptr.gray),
    .q     (rptr_gray_sync)
  );

  // storage, data_out is the head word while empty is low
  fifo_ram u_fifo_ram (
    .wclk    (wclk),
    .wr_fire (wr_fire),
    .waddr   (waddr),
    .wdata   (data_in),
    .raddr   (raddr),
    .rdata   (data_out)
  );

endmodule : async_fifo

`default_nettype wire

/* tb_clk_gen.sv */
/*
  testbench clock and reset
  free running clock with an active low reset held for three of its cycles
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD = 50
) (
  output logic clk,
  output logic rst_n
);

  // free running, first rising edge after one half period
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

  // reset low for three rising edges
  // released 5 ns after the third edge, away from the clock
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #5 rst_n = 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

/* tb_async_fifo.sv */
/*
  async fifo testbench
  table driven writes and reads across two drifting clocks,
  every pop checked against a queue model of the fifo
*/
`timescale 1ns/1ns
`default_nettype none

`include "async_fifo_macros.svh"

module tb_async_fifo import fifo_data_pkg::*; ();

  // longest any single wait may run in cycles of its own clock
  localparam int WAIT_LIMIT = 60;
  localparam int NUM_ROWS   = 6;

  // one stimulus row
  typedef struct packed {
    logic [7:0] wr_cnt;
    logic [7:0] rd_cnt;
    logic       use_lfsr;
    data_t      fixed_val;
    logic       overlap;
  } row_t;

  logic  wclk;
  logic  wrst_n;
  logic  rclk;
  logic  rrst_n;
  logic  w_en;
  logic  r_en;
  data_t data_in;
  data_t data_out;
  logic  full;
  logic  empty;

  row_t        rows [NUM_ROWS];
  // reference model with the oldest word at the front
  data_t       model [$];
  data_t       exp_word;
  logic [19:0] lfsr_q;
  int          errors;
  int          writes_seen;
  int          pops_seen;
  logic        timed_out;

  // 100 ns write clock against a 130 ns read clock
  tb_clk_gen #(.HALF_PERIOD(50)) wclk_gen (.clk(wclk), .rst_n(wrst_n));
  tb_clk_gen #(.HALF_PERIOD(65)) rclk_gen (.clk(rclk), .rst_n(rrst_n));

  async_fifo dut (
    .wclk     (wclk),
    .wrst_n   (wrst_n),
    .w_en     (w_en),
    .data_in  (data_in),
    .full     (full),
    .rclk     (rclk),
    .rrst_n   (rrst_n),
    .r_en     (r_en),
    .data_out (data_out),
    .empty    (empty)
  );

  // fibonacci lfsr with taps 20 and 17 for a maximal length sequence
  function automatic logic [19:0] lfsr_step(input logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};
  endfunction

  // one lfsr step per data bit
  task automatic take_lfsr_byte(output data_t b);
    for (int k = 0; k < `FIFO_DATA_W; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      b[k]   = lfsr_q[0];
    end
  endtask

  task automatic load_table();
    //          wr     rd     lfsr  value  overlap
    rows[0] = '{8'd0,  8'd0,  1'b0, 8'h00, 1'b0};  // idle after reset
    rows[1] = '{8'd5,  8'd5,  1'b0, 8'h30, 1'b0};  // ordering
    rows[2] = '{8'd11, 8'd8,  1'b0, 8'h50, 1'b0};  // fill plus three dropped
    rows[3] = '{8'd0,  8'd4,  1'b0, 8'h00, 1'b0};  // r_en while empty
    rows[4] = '{8'd1,  8'd1,  1'b0, 8'ha5, 1'b0};  // read pointer unmoved
    rows[5] = '{8'd40, 8'd40, 1'b1, 8'h00, 1'b1};  // wrap both pointers
  endtask

  task automatic wait_reset_release();
    int tries;
    tries = 0;
    while ((wrst_n !== 1'b1 || rrst_n !== 1'b1) && !timed_out) begin
      @(posedge wclk);
      tries++;
      if (tries >= WAIT_LIMIT) begin
        errors++;
        timed_out = 1'b1;
        $display("timeout: reset was never released");
      end
    end
  endtask

  task automatic write_words(input row_t row);
    data_t word;
    logic  taken;
    int    tries;
    int    n_acc;
    int    exp_acc;
    n_acc = 0;
    @(posedge wclk);
    #5;
    for (int i = 0; i < int'(row.wr_cnt); i++) begin
      if (timed_out) break;
      if (row.use_lfsr) begin
        take_lfsr_byte(word);
      end else begin
        word = row.fixed_val + data_t'(i);
      end
      w_en    = 1'b1;
      data_in = word;
      taken   = 1'b0;
      tries   = 0;
      // overlapped traffic holds the word and retries while full
      // other rows get one attempt per word
      while (!taken && !timed_out) begin
        @(posedge wclk);
        taken = !full;
        tries++;
        #5;
        if (!row.overlap) break;
        if (!taken && tries >= WAIT_LIMIT) begin
          errors++;
          timed_out = 1'b1;
          $display("timeout: full stayed high for %0d wclk cycles", tries);
        end
      end
      if (taken) n_acc++;
    end
    w_en = 1'b0;
    if (!row.overlap && !timed_out) begin
      // fifo starts each row drained, so at most FIFO_DEPTH go in
      exp_acc = (int'(row.wr_cnt) > `FIFO_DEPTH) ? `FIFO_DEPTH : int'(row.wr_cnt);
      if (n_acc != exp_acc) begin
        errors++;
        $display("mismatch accepted writes: expected %h, actual %h", exp_acc, n_acc);
      end
      if (int'(row.wr_cnt) >= `FIFO_DEPTH && full !== 1'b1) begin
        errors++;
        $display("mismatch full: expected %h, actual %h", 1'b1, full);
      end
    end
  endtask

  task automatic read_words(input row_t row);
    logic popped;
    int   tries;
    @(posedge rclk);
    #5;
    for (int i = 0; i < int'(row.rd_cnt); i++) begin
      if (timed_out) break;
      r_en   = 1'b1;
      popped = 1'b0;
      tries  = 0;
      // r_en stays high across empty cycles and those edges must not pop
      while (!popped && !timed_out) begin
        @(posedge rclk);
        popped = !empty;
        tries++;
        #5;
        if (row.wr_cnt == 0) begin
          if (popped) begin
            errors++;
            $display("mismatch empty: expected %h, actual %h", 1'b1, 1'b0);
          end
          break;
        end
        if (!popped && tries >= WAIT_LIMIT) begin
          errors++;
          timed_out = 1'b1;
          $display("timeout: empty stayed high for %0d rclk cycles", tries);
        end
      end
    end
    r_en = 1'b0;
    // empty rises on the edge of the last pop
    if (row.wr_cnt != 0 && !timed_out && model.size() == 0 && empty !== 1'b1) begin
      errors++;
      $display("mismatch empty: expected %h, actual %h", 1'b1, empty);
    end
  endtask

  task automatic apply_row(input row_t row);
    int tries;
    if (row.overlap) begin
      fork
        write_words(row);
        read_words(row);
      join
    end else begin
      write_words(row);
      read_words(row);
    end
    // full drops once the freed space has crossed into wclk
    tries = 0;
    while (full !== 1'b0 && !timed_out) begin
      @(posedge wclk);
      #5;
      tries++;
      if (full !== 1'b0 && tries >= WAIT_LIMIT) begin
        errors++;
        timed_out = 1'b1;
        $display("timeout: full stayed high for %0d wclk cycles after the row", tries);
      end
    end
    if (!timed_out) begin
      if (empty !== 1'b1) begin
        errors++;
        $display("mismatch empty: expected %h, actual %h", 1'b1, empty);
      end
      if (model.size() != 0) begin
        errors++;
        $display("model still holds %0d words after the row", model.size());
      end
    end
  endtask

  // accepted writes go into the model
  initial begin
    forever begin
      @(posedge wclk);
      if (w_en && !full) begin
        if (model.size() >= `FIFO_DEPTH) begin
          errors++;
          $display("write accepted while the model holds %0d words", model.size());
        end
        model.push_back(data_in);
        writes_seen++;
      end
    end
  end

  // each pop is compared with the head of the model
  initial begin
    forever begin
      @(posedge rclk);
      if (r_en && !empty) begin
        pops_seen++;
        if (model.size() == 0) begin
          errors++;
          $display("pop taken while the model is empty");
        end else begin
          exp_word = model.pop_front();
          if (data_out !== exp_word) begin
            errors++;
            $display("mismatch data_out: expected %h, actual %h", exp_word, data_out);
          end
        end
      end
    end
  end

  initial begin
    w_en        = 1'b0;
    r_en        = 1'b0;
    data_in     = '0;
    lfsr_q      = 20'd84408;
    errors      = 0;
    writes_seen = 0;
    pops_seen   = 0;
    timed_out   = 1'b0;
    load_table();
    wait_reset_release();
    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      apply_row(rows[r]);
    end
    $display("writes %0d, pops %0d, errors %0d", writes_seen, pops_seen, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_async_fifo

`default_nettype wire

/* async_fifo.f */
+incdir+.
fifo_data_pkg.sv
fifo_ptr_pkg.sv
gray_sync.sv
wptr_full.sv
rptr_empty.sv
fifo_ram.sv
async_fifo.sv
tb_clk_gen.sv
tb_async_fifo.sv

/* Makefile */
# verilator build and run for the async fifo testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --top-module tb_async_fifo -f async_fifo.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
